//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_i3c_target_reset \
		-f list.f -o sim
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- bus_event_detect.sv
// Bus event stage that turns sampled SCL/SDA into edge, START, Sr and STOP strobes
`timescale 1ns/100ps
`default_nettype none

module bus_event_detect (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 scl_i,
  input  logic                 sda_i,
  input  logic                 enable_i,
  output i3c_pkg::bus_events_t events_o
);
  import i3c_pkg::*;

  logic        scl_q;
  logic        sda_q;
  logic        scl_d;
  logic        sda_d;
  logic        in_frame_q;
  bus_events_t events_d;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
      scl_d <= 1'b1;
      sda_d <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
      scl_d <= scl_q;
      sda_d <= sda_q;
    end
  end

  always_comb begin
    events_d         = '0;
    events_d.scl_pos = scl_q & ~scl_d;
    events_d.scl_neg = ~scl_q & scl_d;
    events_d.sda_pos = sda_q & ~sda_d;
    events_d.sda_neg = ~sda_q & sda_d;
    // SDA moving under a steady high SCL is a bus condition
    events_d.start   = events_d.sda_neg & scl_q & scl_d & ~in_frame_q;
    events_d.rstart  = events_d.sda_neg & scl_q & scl_d & in_frame_q;
    events_d.stop    = events_d.sda_pos & scl_q & scl_d;
    if (!enable_i) begin
      events_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_frame_q <= 1'b0;
      events_o   <= '0;
    end else begin
      events_o <= events_d;
      if (!enable_i || events_d.stop) begin
        in_frame_q <= 1'b0;
      end else if (events_d.start) begin
        in_frame_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- i3c_pkg.sv
// Bus event struct, FSM state enums, CCC and reset action codes, protocol constants
`default_nettype none

package i3c_pkg;

  // 7-bit broadcast address used by every broadcast CCC
  localparam logic [6:0] BroadcastAddr = 7'h7E;

  // SDA transitions with SCL low that open a Target Reset Pattern
  localparam logic [4:0] TrpToggles = 5'd14;

  // 8 data bits plus the ACK/T bit
  localparam int unsigned FrameBits = 9;

  // One-cycle strobes from the bus event stage
  typedef struct packed {
    logic scl_pos;
    logic scl_neg;
    logic sda_pos;
    logic sda_neg;
    logic start;
    logic rstart;
    logic stop;
  } bus_events_t;

  // RSTACT defining byte values
  typedef enum logic [7:0] {
    RstNone       = 8'h00,
    RstPeripheral = 8'h01,
    RstWhole      = 8'h02
  } rst_action_e;

  typedef enum logic [7:0] {
    CccRstactBcast = 8'h2A
  } ccc_code_e;

  // Decoded RSTACT, valid is a one-cycle strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] action;
  } rstact_t;

  // Target Reset Pattern detector
  typedef enum logic [1:0] {
    Counting,
    SclHigh,
    SawSr
  } trp_state_e;

  // RSTACT frame receiver
  typedef enum logic [2:0] {
    Idle,
    Addr,
    Code,
    Defining,
    Complete
  } rx_state_e;

endpackage

`default_nettype wire

//--- i3c_target_reset.sv
// Top level of the standby target reset logic: event stage, detectors, reset control
`timescale 1ns/100ps
`default_nettype none

module i3c_target_reset (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic       standby_en_i,
  input  logic       peripheral_reset_done_i,
  output logic       peripheral_reset_o,
  output logic       escalated_reset_o,
  output logic [7:0] rst_action_o,
  output logic       rst_action_valid_o
);
  import i3c_pkg::*;

  bus_events_t events;
  logic        trp_detect;
  rstact_t     rstact;

  bus_event_detect u_bus_event_detect (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .scl_i    (scl_i),
    .sda_i    (sda_i),
    .enable_i (standby_en_i),
    .events_o (events)
  );

  target_reset_detect u_target_reset_detect (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .events_i     (events),
    .trp_detect_o (trp_detect)
  );

  rstact_receiver u_rstact_receiver (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .events_i (events),
    .sda_i    (sda_i),
    .rstact_o (rstact)
  );

  reset_control u_reset_control (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .trp_detect_i            (trp_detect),
    .rstact_i                (rstact),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o),
    .rst_action_o            (rst_action_o),
    .rst_action_valid_o      (rst_action_valid_o)
  );

endmodule

`default_nettype wire

//--- list.f
i3c_pkg.sv
bus_event_detect.sv
target_reset_detect.sv
rstact_receiver.sv
reset_control.sv
i3c_target_reset.sv
tb_i3c_target_reset.sv

//--- reset_control.sv
// Combines pattern detection and RSTACT into peripheral and escalated resets
`timescale 1ns/100ps
`default_nettype none

module reset_control (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             trp_detect_i,
  input  i3c_pkg::rstact_t rstact_i,
  input  logic             peripheral_reset_done_i,
  output logic             peripheral_reset_o,
  output logic             escalated_reset_o,
  output logic [7:0]       rst_action_o,
  output logic             rst_action_valid_o
);
  import i3c_pkg::*;

  logic escalate_q;
  logic periph_req;
  logic escalate_req;

  // First pattern resets the peripheral, a later one escalates
  assign periph_req   = (rstact_i.valid && rstact_i.action == RstPeripheral) ||
                        (trp_detect_i && !escalate_q);
  assign escalate_req = (rstact_i.valid && rstact_i.action == RstWhole) ||
                        (trp_detect_i && escalate_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      escalate_q         <= 1'b0;
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
      rst_action_valid_o <= 1'b0;
      rst_action_o       <= RstNone;
    end else begin
      if (trp_detect_i) begin
        escalate_q <= 1'b1;
      end
      // Done has priority over a new request
      if (peripheral_reset_done_i) begin
        peripheral_reset_o <= 1'b0;
      end else if (periph_req) begin
        peripheral_reset_o <= 1'b1;
      end
      if (escalate_req) begin
        escalated_reset_o <= 1'b1;
      end
      rst_action_valid_o <= rstact_i.valid;
      if (rstact_i.valid) begin
        rst_action_o <= rstact_i.action;
      end
    end
  end

endmodule

`default_nettype wire

//--- rstact_receiver.sv
// Frame deserializer that decodes a broadcast RSTACT CCC and its defining byte
`timescale 1ns/100ps
`default_nettype none

module rstact_receiver (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  i3c_pkg::bus_events_t events_i,
  input  logic                 sda_i,
  output i3c_pkg::rstact_t     rstact_o
);
  import i3c_pkg::*;

  rx_state_e  state_q;
  rx_state_e  state_d;
  logic [3:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic [7:0] action_q;
  logic       byte_done;
  logic       restart;
  logic       valid_q;

  assign restart = events_i.start | events_i.rstart;

  // The ninth SCL rise is the ACK/T bit, the byte is complete by then
  assign byte_done = events_i.scl_pos && (bit_cnt_q == 4'(FrameBits - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
    end else if (restart || byte_done) begin
      bit_cnt_q <= '0;
    end else if (events_i.scl_pos) begin
      bit_cnt_q <= bit_cnt_q + 4'd1;
    end
  end

  // MSB first, ACK/T bit is not shifted in
  always_ff @(posedge clk_i) begin
    if (events_i.scl_pos && !byte_done) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

  always_comb begin
    state_d = state_q;
    if (restart) begin
      state_d = Addr;
    end else if (events_i.stop) begin
      state_d = Idle;
    end else if (byte_done) begin
      unique case (state_q)
        Addr: begin
          // Broadcast address with the write bit
          if (shift_q == {BroadcastAddr, 1'b0}) begin
            state_d = Code;
          end else begin
            state_d = Idle;
          end
        end
        Code: begin
          if (shift_q == CccRstactBcast) begin
            state_d = Defining;
          end else begin
            state_d = Idle;
          end
        end
        Defining: begin
          state_d = Complete;
        end
        // Extra bytes after the defining byte void the command
        default: begin
          state_d = Idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Defining && state_d == Complete) begin
      action_q <= shift_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= (state_q == Complete) && events_i.stop;
    end
  end

  assign rstact_o = '{valid: valid_q, action: action_q};

endmodule

`default_nettype wire

//--- target_reset_detect.sv
// FSM that recognizes the Target Reset Pattern: SDA toggles, Sr, then STOP
`timescale 1ns/100ps
`default_nettype none

module target_reset_detect (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  i3c_pkg::bus_events_t events_i,
  output logic                 trp_detect_o
);
  import i3c_pkg::*;

  trp_state_e state_q;
  trp_state_e state_d;
  logic [4:0] toggles_q;
  logic [4:0] toggles_d;
  logic       detect_d;
  logic       sda_toggle;
  logic       scl_edge;
  logic       any_event;

  // An SDA edge that is not a bus condition happened with SCL low
  assign sda_toggle = (events_i.sda_pos | events_i.sda_neg) &
                      ~(events_i.start | events_i.rstart | events_i.stop);
  assign scl_edge   = events_i.scl_pos | events_i.scl_neg;
  assign any_event  = |events_i;

  always_comb begin
    state_d   = state_q;
    toggles_d = toggles_q;
    detect_d  = 1'b0;
    unique case (state_q)
      Counting: begin
        if (scl_edge) begin
          toggles_d = '0;
          if (events_i.scl_pos && toggles_q == TrpToggles) begin
            state_d = SclHigh;
          end
        end else if (sda_toggle && toggles_q != TrpToggles) begin
          toggles_d = toggles_q + 5'd1;
        end
      end
      SclHigh: begin
        if (events_i.start || events_i.rstart) begin
          state_d = SawSr;
        end else if (any_event) begin
          state_d = Counting;
        end
      end
      SawSr: begin
        if (events_i.stop) begin
          detect_d = 1'b1;
          state_d  = Counting;
        end else if (any_event) begin
          state_d = Counting;
        end
      end
      default: begin
        state_d   = Counting;
        toggles_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Counting;
      toggles_q    <= '0;
      trp_detect_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      toggles_q    <= toggles_d;
      trp_detect_o <= detect_d;
    end
  end

endmodule

`default_nettype wire

//--- tb_i3c_target_reset.sv
// Testbench for the standby target reset logic: bus driver tasks, reference model, checks
`timescale 1ns/100ps
`default_nettype none

module tb_i3c_target_reset;

  localparam int ResetCycles   = 10;
  localparam int NumResets     = 6;
  localparam int NumRstact     = 12;
  // Frames and patterns driven over the whole run
  localparam int NumTrans      = 31;
  localparam int TimeoutCycles = 2 * (NumTrans * 40 * 5) + NumResets * ResetCycles;

  logic       clk_i;
  logic       rst_ni;
  logic       scl_i;
  logic       sda_i;
  logic       standby_en_i;
  logic       peripheral_reset_done_i;
  logic       peripheral_reset_o;
  logic       escalated_reset_o;
  logic [7:0] rst_action_o;
  logic       rst_action_valid_o;

  // Reference model
  logic       esc_flag;
  logic       exp_periph;
  logic       exp_escal;
  logic [7:0] exp_action;
  int         exp_pulses;
  int         seen_pulses = 0;
  int         cycle_count = 0;
  int         check_count;
  int         error_count;
  int         test_first_error;

  i3c_target_reset dut0 (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .scl_i                   (scl_i),
    .sda_i                   (sda_i),
    .standby_en_i            (standby_en_i),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o),
    .rst_action_o            (rst_action_o),
    .rst_action_valid_o      (rst_action_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  always @(negedge clk_i) begin
    if (rst_action_valid_o) begin
      seen_pulses <= seen_pulses + 1;
    end
  end

  initial begin
    wait (cycle_count >= TimeoutCycles);
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("ERRORS FOUND");
    $finish;
  end

  // Each bus level is held for 2 to 5 clocks
  task automatic hold_level();
    repeat ($urandom_range(5, 2)) @(negedge clk_i);
  endtask

  task automatic drive_scl(input logic v);
    scl_i = v;
    hold_level();
  endtask

  task automatic drive_sda(input logic v);
    sda_i = v;
    hold_level();
  endtask

  task automatic bus_start();
    drive_sda(1'b0);
    drive_scl(1'b0);
  endtask

  task automatic bus_rstart();
    drive_sda(1'b1);
    drive_scl(1'b1);
    drive_sda(1'b0);
    drive_scl(1'b0);
  endtask

  task automatic bus_stop();
    drive_sda(1'b0);
    drive_scl(1'b1);
    drive_sda(1'b1);
  endtask

  // MSB first, then the ACK bit left released
  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= -1; i--) begin
      drive_sda(i >= 0 ? b[i] : 1'b1);
      drive_scl(1'b1);
      drive_scl(1'b0);
    end
  endtask

  task automatic send_rstact(input logic [7:0] action);
    bus_start();
    send_byte(8'hFC);
    send_byte(8'h2A);
    send_byte(action);
    bus_stop();
  endtask

  // glitch_at of zero means no SCL pulse among the toggles
  task automatic send_pattern(input int toggles, input int glitch_at);
    drive_scl(1'b0);
    for (int i = 1; i <= toggles; i++) begin
      drive_sda(!sda_i);
      if (i == glitch_at) begin
        drive_scl(1'b1);
        drive_scl(1'b0);
      end
    end
    drive_scl(1'b1);
    // Odd count leaves SDA low
    if (!sda_i) begin
      drive_sda(1'b1);
    end
    drive_sda(1'b0);
    drive_sda(1'b1);
  endtask

  task automatic reset_dut();
    rst_ni = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni     = 1'b1;
    esc_flag   = 1'b0;
    exp_periph = 1'b0;
    exp_escal  = 1'b0;
    exp_action = 8'h00;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic model_rstact(input logic [7:0] action);
    exp_pulses = exp_pulses + 1;
    exp_action = action;
    if (action == 8'h01) begin
      exp_periph = 1'b1;
    end
    if (action == 8'h02) begin
      exp_escal = 1'b1;
    end
  endtask

  // First pattern resets the peripheral, any later one escalates
  task automatic model_pattern();
    if (esc_flag) begin
      exp_escal = 1'b1;
    end else begin
      exp_periph = 1'b1;
    end
    esc_flag = 1'b1;
  endtask

  task automatic pulse_done();
    peripheral_reset_done_i = 1'b1;
    @(negedge clk_i);
    peripheral_reset_done_i = 1'b0;
    exp_periph = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      error_count = error_count + 1;
      $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_outputs();
    repeat (8) @(negedge clk_i);
    check_value("peripheral_reset_o", {7'b0, peripheral_reset_o}, {7'b0, exp_periph});
    check_value("escalated_reset_o", {7'b0, escalated_reset_o}, {7'b0, exp_escal});
    check_value("rst_action_o", rst_action_o, exp_action);
    check_count = check_count + 1;
    if (seen_pulses < exp_pulses) begin
      error_count = error_count + 1;
      $display("rst_action_valid_o did not pulse for an accepted RSTACT");
      exp_pulses = seen_pulses;
    end else if (seen_pulses > exp_pulses) begin
      error_count = error_count + 1;
      $display("rst_action_valid_o pulsed although no RSTACT was accepted");
      exp_pulses = seen_pulses;
    end
  endtask

  task automatic finish_test(input string name);
    if (error_count == test_first_error) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: %0d failing checks", name, error_count - test_first_error);
    end
    test_first_error = error_count;
  endtask

  initial begin
    int         n;
    logic [7:0] b;
    rst_ni                  = 1'b0;
    scl_i                   = 1'b1;
    sda_i                   = 1'b1;
    standby_en_i            = 1'b1;
    peripheral_reset_done_i = 1'b0;
    exp_pulses              = 0;
    check_count             = 0;
    error_count             = 0;
    test_first_error        = 0;
    void'($urandom(32'h8ac4199f));
    @(negedge clk_i);
    reset_dut();

    for (int i = 0; i < NumRstact; i++) begin
      case (i % 4)
        0: b = 8'h01;
        2: b = 8'h02;
        default: b = 8'($urandom);
      endcase
      send_rstact(b);
      model_rstact(b);
      check_outputs();
      if (exp_periph) begin
        pulse_done();
        check_outputs();
      end
    end
    finish_test("rstact_random_byte");

    reset_dut();
    send_pattern(14, 0);
    model_pattern();
    check_outputs();
    pulse_done();
    check_outputs();
    send_pattern(14, 0);
    model_pattern();
    check_outputs();
    finish_test("pattern_escalation");

    reset_dut();
    for (int i = 0; i < 4; i++) begin
      n = $urandom_range(13, 1);
      send_pattern(n, 0);
      check_outputs();
      send_pattern(14, $urandom_range(13, 1));
      check_outputs();
    end
    finish_test("pattern_short_or_glitch");

    reset_dut();
    for (int i = 0; i < 2; i++) begin
      do b = 8'($urandom); while (b == 8'hFC);
      bus_start();
      send_byte(b);
      send_byte(8'h2A);
      send_byte(8'h01);
      bus_stop();
      check_outputs();
      do b = 8'($urandom); while (b == 8'h2A);
      bus_start();
      send_byte(8'hFC);
      send_byte(b);
      send_byte(8'h01);
      bus_stop();
      check_outputs();
      bus_start();
      send_byte(8'hFC);
      send_byte(8'h2A);
      bus_stop();
      check_outputs();
    end
    finish_test("rstact_bad_frames");

    reset_dut();
    standby_en_i = 1'b0;
    send_rstact(8'h01);
    check_outputs();
    send_pattern(14, 0);
    check_outputs();
    standby_en_i = 1'b1;
    check_outputs();
    finish_test("standby_disabled");

    reset_dut();
    bus_start();
    send_byte(8'hFC);
    send_byte(8'h2A);
    bus_rstart();
    send_byte(8'hFC);
    send_byte(8'h2A);
    send_byte(8'h01);
    bus_stop();
    model_rstact(8'h01);
    check_outputs();
    pulse_done();
    check_outputs();
    finish_test("rstact_after_rstart");

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
